// ==== common/cr16Pkg.sv ====
`default_nettype none

package cr16Pkg;

	////////////////////////////////////////////////////////////////////////////
	// Data and field types
	////////////////////////////////////////////////////////////////////////////

	// Data word held in registers and moved through the datapath
	typedef logic [15:0] word_t;

	// Register number, sixteen registers
	typedef logic [3:0] regIndex_t;

	// Major opcode in the upper nibble, extension in the lower nibble
	typedef logic [7:0] opcode_t;

	// Processor status flags
	typedef logic [4:0] flags_t;

	// Major, destination, extension, source or low immediate
	typedef logic [15:0] instr_t;

	////////////////////////////////////////////////////////////////////////////
	// Flag bit positions
	////////////////////////////////////////////////////////////////////////////

	localparam int flagNegative = 0;
	localparam int flagLow      = 1;
	localparam int flagOverflow = 2;
	localparam int flagCarry    = 3;
	localparam int flagZero     = 4;

	////////////////////////////////////////////////////////////////////////////
	// Opcode encodings
	////////////////////////////////////////////////////////////////////////////

	// Major nibble values; any other major is an immediate form
	localparam logic [3:0] opNormal = 4'b0000;
	localparam logic [3:0] opShift  = 4'b1000;

	// Register and immediate forms
	localparam logic [3:0] extAdd  = 4'b0101;
	localparam logic [3:0] extAddu = 4'b0110;
	localparam logic [3:0] extSub  = 4'b1001;
	localparam logic [3:0] extCmp  = 4'b1011;
	localparam logic [3:0] extAnd  = 4'b0001;
	localparam logic [3:0] extOr   = 4'b0010;
	localparam logic [3:0] extXor  = 4'b0011;

	// Shift forms, only meaningful under opShift
	localparam logic [3:0] extLsh  = 4'b0100;
	localparam logic [3:0] extRsh  = 4'b1100;
	localparam logic [3:0] extLshi = 4'b0000;
	localparam logic [3:0] extRshi = 4'b0001;
	localparam logic [3:0] extAlsh = 4'b0110;
	localparam logic [3:0] extArsh = 4'b1110;

endpackage

`default_nettype wire

// ==== alu/alu.sv ====
`default_nettype none

module alu
(
	input  wire cr16Pkg::word_t   a,
	input  wire cr16Pkg::word_t   b,
	input  wire logic [3:0]       immLow,
	input  wire cr16Pkg::opcode_t opcode,
	output cr16Pkg::word_t        aluResult,
	output cr16Pkg::flags_t       aluFlags,
	output logic                  opLegal
);

	logic [3:0]      major;
	logic [3:0]      ext;
	cr16Pkg::word_t  immWord;

	// Operation code and second operand after form decode
	logic [3:0]      arithOp;
	cr16Pkg::word_t  operand;
	logic            isShift;
	logic            isImm;

	logic [16:0]     addSum;
	cr16Pkg::word_t  subDiff;
	logic            addOverflow;
	logic            subOverflow;
	logic            lessThan;

	assign major = opcode[7:4];
	assign ext = opcode[3:0];

	// Eight-bit immediate, zero extended
	assign immWord = {8'h00, ext, immLow};

	////////////////////////////////////////////////////////////////////////////
	// Form decode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		isShift = 1'b0;
		isImm = 1'b0;
		arithOp = ext;
		operand = b;
		if (major == cr16Pkg::opShift)
			isShift = 1'b1;
		else if (major != cr16Pkg::opNormal)
		begin
			// Immediate form names its operation with the major nibble
			isImm = 1'b1;
			arithOp = major;
			operand = immWord;
		end
	end

	// Shared adder and subtractor
	assign addSum = {1'b0, a} + {1'b0, operand};
	assign subDiff = a - operand;

	// Signed overflow from the operand actually used
	assign addOverflow = (a[15] == operand[15]) && (addSum[15] != a[15]);
	assign subOverflow = (a[15] != operand[15]) && (subDiff[15] != a[15]);
	assign lessThan = $signed(a) < $signed(operand);

	////////////////////////////////////////////////////////////////////////////
	// Operation select and flags
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		aluResult = '0;
		aluFlags = '0;
		opLegal = 1'b0;

		if (isShift)
		begin
			// Flags stay clear for every shift
			opLegal = 1'b1;
			case (ext)
				cr16Pkg::extLsh, cr16Pkg::extAlsh:
					aluResult = a << b;
				cr16Pkg::extRsh:
					aluResult = a >> b;
				cr16Pkg::extArsh:
					aluResult = $signed(a) >>> b;
				cr16Pkg::extLshi:
					aluResult = b << 1;
				cr16Pkg::extRshi:
					aluResult = b >> 1;
				default:
					opLegal = 1'b0;
			endcase
		end
		else
		begin
			opLegal = 1'b1;
			case (arithOp)
				cr16Pkg::extAdd:
				begin
					aluResult = addSum[15:0];
					aluFlags[cr16Pkg::flagOverflow] = addOverflow;
				end
				cr16Pkg::extAddu:
				begin
					aluResult = addSum[15:0];
					aluFlags[cr16Pkg::flagCarry] = addSum[16];
				end
				cr16Pkg::extSub:
				begin
					aluResult = subDiff;
					aluFlags[cr16Pkg::flagOverflow] = subOverflow;
				end
				cr16Pkg::extCmp:
				begin
					// Result stays zero, only low and negative report
					aluFlags[cr16Pkg::flagLow] = lessThan;
					aluFlags[cr16Pkg::flagNegative] = lessThan;
				end
				cr16Pkg::extAnd:
					aluResult = a & operand;
				cr16Pkg::extOr:
					aluResult = a | operand;
				cr16Pkg::extXor:
					aluResult = a ^ operand;
				default:
					opLegal = 1'b0;
			endcase

			// Logic ops have no immediate form
			if (isImm && arithOp != cr16Pkg::extAdd && arithOp != cr16Pkg::extAddu
				&& arithOp != cr16Pkg::extSub && arithOp != cr16Pkg::extCmp)
				opLegal = 1'b0;

			if (opLegal && arithOp != cr16Pkg::extCmp)
				aluFlags[cr16Pkg::flagZero] = (aluResult == '0);
		end

		// Undefined opcodes leave nothing behind
		if (!opLegal)
		begin
			aluResult = '0;
			aluFlags = '0;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/registerFile.sv ====
`default_nettype none

module registerFile
(
	input  wire                     clk,
	input  wire                     reset,

	// Read ports
	input  wire cr16Pkg::regIndex_t readAddrA,
	input  wire cr16Pkg::regIndex_t readAddrB,
	output cr16Pkg::word_t          readDataA,
	output cr16Pkg::word_t          readDataB,

	// Write port
	input  wire cr16Pkg::regIndex_t writeAddr,
	input  wire cr16Pkg::word_t     writeData,
	input  wire                     writeEnable
);

	cr16Pkg::word_t regs [16];

	// Combinational reads see a write from the previous edge
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 16; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (writeEnable)
		begin
			regs[writeAddr] <= writeData;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/instructionControl.sv ====
`default_nettype none

module instructionControl
(
	input  wire                     clk,
	input  wire                     reset,
	input  wire cr16Pkg::instr_t    instr,
	input  wire                     instrValid,

	// Operand fetch and decode
	output cr16Pkg::regIndex_t      readAddrA,
	output cr16Pkg::regIndex_t      readAddrB,
	output cr16Pkg::opcode_t        opcode,
	output logic [3:0]              immLow,

	// From the ALU
	input  wire cr16Pkg::word_t     aluResult,
	input  wire cr16Pkg::flags_t    aluFlags,
	input  wire                     opLegal,

	// Writeback
	output cr16Pkg::regIndex_t      writeAddr,
	output cr16Pkg::word_t          writeData,
	output logic                    writeEnable,

	// Visible state
	output cr16Pkg::word_t          result,
	output cr16Pkg::flags_t         flags,
	output logic                    resultValid,
	output logic                    illegalOp
);

	logic [3:0]  major;
	logic [3:0]  ext;
	logic        isCompare;
	logic        accept;

	////////////////////////////////////////////////////////////////////////////
	// Field split
	////////////////////////////////////////////////////////////////////////////

	assign major = instr[15:12];
	assign ext = instr[7:4];

	// Destination doubles as first operand
	assign readAddrA = instr[11:8];
	assign readAddrB = instr[3:0];
	assign immLow = instr[3:0];
	assign opcode = {major, ext};

	// Compare in register or immediate form
	assign isCompare = (major == cr16Pkg::opNormal && ext == cr16Pkg::extCmp)
		|| (major == cr16Pkg::extCmp);

	assign accept = instrValid && opLegal;

	// Writeback lands at the strobe edge
	assign writeAddr = instr[11:8];
	assign writeData = aluResult;
	assign writeEnable = accept && !isCompare;

	////////////////////////////////////////////////////////////////////////////
	// Status register and visible result
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			flags <= '0;
			result <= '0;
		end
		else if (accept)
		begin
			flags <= aluFlags;
			result <= aluResult;
		end
	end

	// Completion and illegal pulses, one cycle after the strobe
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resultValid <= 1'b0;
			illegalOp <= 1'b0;
		end
		else
		begin
			resultValid <= accept;
			illegalOp <= instrValid && !opLegal;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/cr16Execute.sv ====
`default_nettype none

module cr16Execute
(
	input  wire                  clk,
	input  wire                  reset,
	input  wire cr16Pkg::instr_t instr,
	input  wire                  instrValid,
	output cr16Pkg::word_t       result,
	output cr16Pkg::flags_t      flags,
	output logic                 resultValid,
	output logic                 illegalOp
);

	cr16Pkg::regIndex_t readAddrA;
	cr16Pkg::regIndex_t readAddrB;
	cr16Pkg::word_t     readDataA;
	cr16Pkg::word_t     readDataB;
	cr16Pkg::regIndex_t writeAddr;
	cr16Pkg::word_t     writeData;
	logic               writeEnable;

	cr16Pkg::opcode_t   opcode;
	logic [3:0]         immLow;
	cr16Pkg::word_t     aluResult;
	cr16Pkg::flags_t    aluFlags;
	logic               opLegal;

	// Decode, writeback steering and status
	instructionControl control
	(
		.clk         (clk),
		.reset       (reset),
		.instr       (instr),
		.instrValid  (instrValid),
		.readAddrA   (readAddrA),
		.readAddrB   (readAddrB),
		.opcode      (opcode),
		.immLow      (immLow),
		.aluResult   (aluResult),
		.aluFlags    (aluFlags),
		.opLegal     (opLegal),
		.writeAddr   (writeAddr),
		.writeData   (writeData),
		.writeEnable (writeEnable),
		.result      (result),
		.flags       (flags),
		.resultValid (resultValid),
		.illegalOp   (illegalOp)
	);

	registerFile regFile
	(
		.clk         (clk),
		.reset       (reset),
		.readAddrA   (readAddrA),
		.readAddrB   (readAddrB),
		.readDataA   (readDataA),
		.readDataB   (readDataB),
		.writeAddr   (writeAddr),
		.writeData   (writeData),
		.writeEnable (writeEnable)
	);

	alu execUnit
	(
		.a         (readDataA),
		.b         (readDataB),
		.immLow    (immLow),
		.opcode    (opcode),
		.aluResult (aluResult),
		.aluFlags  (aluFlags),
		.opLegal   (opLegal)
	);

endmodule

`default_nettype wire

// ==== verification/clockGen.sv ====
`default_nettype none

module clockGen
(
	output logic clk,
	output logic reset
);

	// 100-unit period
	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Held for ten rising edges
	initial
	begin
		reset = 1'b1;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== verification/cr16Execute_asserts.sv ====
`default_nettype none

module cr16Execute_asserts
(
	input wire clk,
	input wire reset,
	input wire instrValid,
	input wire resultValid,
	input wire illegalOp
);

	int failures = 0;

	// Completion and illegal pulses exclude each other
	assert property (@(posedge clk) disable iff (reset) !(resultValid && illegalOp))
	else
	begin
		$error("resultValid and illegalOp high together");
		failures++;
	end

	// One cycle from strobe to pulse
	assert property (@(posedge clk) disable iff (reset)
		(resultValid || illegalOp) |-> $past(instrValid))
	else
	begin
		$error("pulse without a strobe one cycle earlier");
		failures++;
	end

	// Reset clears both pulses
	assert property (@(posedge clk) reset |=> !resultValid && !illegalOp)
	else
	begin
		$error("pulse high during reset");
		failures++;
	end

endmodule

bind instructionControl cr16Execute_asserts checks
(
	.clk         (clk),
	.reset       (reset),
	.instrValid  (instrValid),
	.resultValid (resultValid),
	.illegalOp   (illegalOp)
);

`default_nettype wire

// ==== verification/tbCr16Execute.sv ====
`default_nettype none

module tbCr16Execute;

	localparam int opsPerTest = 100;
	localparam int seedLength = 62;
	localparam int testCount = 6;
	localparam int totalInstr = 1 + 5 * (seedLength + opsPerTest);
	localparam int cycleLimit = 10 + totalInstr + testCount + 100;

	localparam logic [3:0] arithOps [6] = '{cr16Pkg::extAdd, cr16Pkg::extAddu,
		cr16Pkg::extSub, cr16Pkg::extAnd, cr16Pkg::extOr, cr16Pkg::extXor};
	localparam logic [3:0] shiftOps [6] = '{cr16Pkg::extLsh, cr16Pkg::extAlsh,
		cr16Pkg::extRsh, cr16Pkg::extArsh, cr16Pkg::extLshi, cr16Pkg::extRshi};
	localparam logic [3:0] immOps [4] = '{cr16Pkg::extAdd, cr16Pkg::extAddu,
		cr16Pkg::extSub, cr16Pkg::extCmp};
	localparam logic [3:0] undefinedMajors [10] = '{4'h1, 4'h2, 4'h3, 4'h4, 4'h7,
		4'hA, 4'hC, 4'hD, 4'hE, 4'hF};

	logic            clk;
	logic            reset;
	cr16Pkg::instr_t instr;
	logic            instrValid;
	cr16Pkg::word_t  result;
	cr16Pkg::flags_t flags;
	logic            resultValid;
	logic            illegalOp;

	// Reference state
	cr16Pkg::word_t  modelRegs [16];
	cr16Pkg::word_t  modelResult;
	cr16Pkg::flags_t modelFlags;

	logic [31:0]     rngState = 32'heb509a22;
	cr16Pkg::instr_t pending [$];
	string           testName;
	int              testErrors;
	int              errorCount = 0;
	int              checkCount = 0;
	int              testsRun = 0;
	int              testsFailed = 0;

	clockGen clocks
	(
		.clk   (clk),
		.reset (reset)
	);

	cr16Execute uut
	(
		.clk         (clk),
		.reset       (reset),
		.instr       (instr),
		.instrValid  (instrValid),
		.result      (result),
		.flags       (flags),
		.resultValid (resultValid),
		.illegalOp   (illegalOp)
	);

	function automatic logic [31:0] nextRandom();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	function automatic cr16Pkg::instr_t encode(logic [3:0] major, logic [3:0] dest,
		logic [3:0] ext, logic [3:0] low);
		return {major, dest, ext, low};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model, returns whether the opcode is defined
	////////////////////////////////////////////////////////////////////////////

	function automatic logic modelStep(cr16Pkg::instr_t ins);
		logic [3:0]         major;
		logic [3:0]         ext;
		logic [3:0]         kind;
		cr16Pkg::regIndex_t dest;
		cr16Pkg::word_t     a;
		cr16Pkg::word_t     b;
		cr16Pkg::word_t     op;
		cr16Pkg::word_t     res;
		cr16Pkg::flags_t    f;
		int                 sa;
		int                 so;
		int                 wide;
		major = ins[15:12];
		dest = ins[11:8];
		ext = ins[7:4];
		a = modelRegs[dest];
		b = modelRegs[ins[3:0]];
		kind = (major == cr16Pkg::opNormal) ? ext : major;
		op = (major == cr16Pkg::opNormal) ? b : {8'h00, ext, ins[3:0]};
		sa = int'($signed(a));
		so = int'($signed(op));
		res = '0;
		f = '0;
		if (major == cr16Pkg::opShift)
		begin
			// Amounts of 16 and above empty the word
			case (ext)
				cr16Pkg::extLsh, cr16Pkg::extAlsh: res = (b >= 16) ? '0 : a << b[3:0];
				cr16Pkg::extRsh: res = (b >= 16) ? '0 : a >> b[3:0];
				cr16Pkg::extArsh: res = (b >= 16) ? {16{a[15]}} :
					(a >> b[3:0]) | (a[15] ? ~(16'hffff >> b[3:0]) : 16'h0000);
				cr16Pkg::extLshi: res = b << 1;
				cr16Pkg::extRshi: res = b >> 1;
				default: return 1'b0;
			endcase
		end
		else
		begin
			case (kind)
				cr16Pkg::extAdd: wide = sa + so;
				cr16Pkg::extSub: wide = sa - so;
				cr16Pkg::extAddu: wide = int'(a) + int'(op);
				cr16Pkg::extCmp: wide = 0;
				cr16Pkg::extAnd: wide = int'(a & op);
				cr16Pkg::extOr: wide = int'(a | op);
				cr16Pkg::extXor: wide = int'(a ^ op);
				default: return 1'b0;
			endcase
			// No immediate logic ops
			if (major != cr16Pkg::opNormal && kind != cr16Pkg::extAdd
				&& kind != cr16Pkg::extAddu && kind != cr16Pkg::extSub
				&& kind != cr16Pkg::extCmp)
				return 1'b0;
			res = wide[15:0];
			f[cr16Pkg::flagOverflow] = (kind == cr16Pkg::extAdd || kind == cr16Pkg::extSub)
				&& (wide > 32767 || wide < -32768);
			f[cr16Pkg::flagCarry] = (kind == cr16Pkg::extAddu) && (wide > 65535);
			f[cr16Pkg::flagLow] = (kind == cr16Pkg::extCmp) && (sa < so);
			f[cr16Pkg::flagNegative] = f[cr16Pkg::flagLow];
			f[cr16Pkg::flagZero] = (kind != cr16Pkg::extCmp) && (res == '0);
		end
		modelResult = res;
		modelFlags = f;
		if (major == cr16Pkg::opShift || kind != cr16Pkg::extCmp)
			modelRegs[dest] = res;
		return 1'b1;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic checkWord(string name, cr16Pkg::word_t expected, cr16Pkg::word_t actual);
		checkCount++;
		if (actual !== expected)
		begin
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic checkFlags(string name, cr16Pkg::flags_t expected,
		cr16Pkg::flags_t actual);
		checkCount++;
		if (actual !== expected)
		begin
			$display("FAILED %s: expected %b, actual %b", name, expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic checkBit(string name, logic expected, logic actual);
		checkCount++;
		if (actual !== expected)
		begin
			$display("FAILED %s: expected %b, actual %b", name, expected, actual);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic checkStep(cr16Pkg::instr_t ins, int index);
		logic  legal;
		string tag;
		legal = modelStep(ins);
		tag = $sformatf("%s #%0d (%h)", testName, index, ins);
		checkBit({tag, " resultValid"}, legal, resultValid);
		checkBit({tag, " illegalOp"}, !legal, illegalOp);
		checkWord({tag, " result"}, modelResult, result);
		checkFlags({tag, " flags"}, modelFlags, flags);
	endtask

	// Back-to-back issue, each result checked one cycle after its strobe
	task automatic runSequence();
		int count;
		count = pending.size();
		for (int i = 0; i <= count; i++)
		begin
			@(posedge clk);
			if (i < count)
			begin
				instr <= pending[i];
				instrValid <= 1'b1;
			end
			else
				instrValid <= 1'b0;
			@(negedge clk);
			if (i > 0)
				checkStep(pending[i - 1], i - 1);
		end
		pending.delete();
	endtask

	// r15 holds 8 as shift amount while r0 to r14 are built from two bytes
	task automatic seedRegisters();
		logic [31:0]        r;
		cr16Pkg::word_t     value;
		cr16Pkg::regIndex_t idx;
		pending.push_back(encode(cr16Pkg::opNormal, 4'd15, cr16Pkg::extXor, 4'd15));
		pending.push_back(encode(cr16Pkg::extAddu, 4'd15, 4'h0, 4'h8));
		for (int i = 0; i < 15; i++)
		begin
			r = nextRandom();
			idx = 4'(i);
			value = r[31:16];
			// Some small values so shift amounts land both below and above 16
			if (r[9:8] == 2'b00)
				value = value % 16'd24;
			pending.push_back(encode(cr16Pkg::opNormal, idx, cr16Pkg::extXor, idx));
			pending.push_back(encode(cr16Pkg::extAddu, idx, value[15:12], value[11:8]));
			pending.push_back(encode(cr16Pkg::opShift, idx, cr16Pkg::extLsh, 4'd15));
			pending.push_back(encode(cr16Pkg::extAddu, idx, value[7:4], value[3:0]));
		end
	endtask

	task automatic startTest(string name);
		testName = name;
		testErrors = 0;
	endtask

	task automatic finishTest();
		testsRun++;
		if (testErrors == 0)
			$display("PASS %s", testName);
		else
		begin
			$display("FAIL %s with %0d errors", testName, testErrors);
			testsFailed++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		logic [31:0]        r;
		cr16Pkg::regIndex_t dest;
		cr16Pkg::regIndex_t nextDest;
		instr = '0;
		instrValid = 1'b0;
		for (int i = 0; i < 16; i++)
			modelRegs[i] = '0;
		modelResult = '0;
		modelFlags = '0;
		@(negedge clk);
		while (reset)
			@(negedge clk);

		startTest("reset");
		checkWord("reset result", '0, result);
		checkFlags("reset flags", '0, flags);
		checkBit("reset resultValid", 1'b0, resultValid);
		checkBit("reset illegalOp", 1'b0, illegalOp);
		pending.push_back(encode(cr16Pkg::opNormal, 4'd1, cr16Pkg::extAdd, 4'd2));
		runSequence();
		finishTest();

		startTest("register arithmetic");
		seedRegisters();
		for (int i = 0; i < opsPerTest; i++)
		begin
			r = nextRandom();
			pending.push_back(encode(cr16Pkg::opNormal, r[19:16], arithOps[r[27:24] % 6],
				r[23:20]));
		end
		runSequence();
		finishTest();

		// Each compare is followed by a readback of its destination
		startTest("compare");
		seedRegisters();
		for (int i = 0; i < opsPerTest / 2; i++)
		begin
			r = nextRandom();
			if (r[28])
				pending.push_back(encode(cr16Pkg::opNormal, r[19:16], cr16Pkg::extCmp, r[23:20]));
			else
				pending.push_back(encode(cr16Pkg::extCmp, r[19:16], r[27:24], r[23:20]));
			pending.push_back(encode(cr16Pkg::opNormal, r[19:16], cr16Pkg::extOr, r[19:16]));
		end
		runSequence();
		finishTest();

		startTest("shifts");
		seedRegisters();
		for (int i = 0; i < opsPerTest; i++)
		begin
			r = nextRandom();
			pending.push_back(encode(cr16Pkg::opShift, r[19:16], shiftOps[r[27:24] % 6],
				r[23:20]));
		end
		runSequence();
		finishTest();

		// Chains on one destination, moved on by a register add
		startTest("immediates");
		seedRegisters();
		dest = 4'd3;
		for (int i = 0; i < opsPerTest; i++)
		begin
			r = nextRandom();
			if (i % 8 == 7)
			begin
				nextDest = r[19:16];
				pending.push_back(encode(cr16Pkg::opNormal, nextDest, cr16Pkg::extAdd, dest));
				dest = nextDest;
			end
			else
				pending.push_back(encode(immOps[r[25:24]], dest, r[23:20], r[31:28]));
		end
		runSequence();
		finishTest();

		startTest("illegal opcodes");
		seedRegisters();
		for (int i = 0; i < opsPerTest / 2; i++)
		begin
			r = nextRandom();
			case (r[29:28])
				2'd2: pending.push_back(encode(cr16Pkg::opNormal, r[19:16], 4'hF, r[23:20]));
				2'd3: pending.push_back(encode(cr16Pkg::opShift, r[19:16], 4'hD, r[23:20]));
				default: pending.push_back(encode(undefinedMajors[r[27:24] % 10], r[19:16],
					r[23:20], r[15:12]));
			endcase
			pending.push_back(encode(cr16Pkg::opNormal, r[11:8], cr16Pkg::extAdd, r[7:4]));
		end
		runSequence();
		finishTest();

		if (uut.control.checks.failures != 0)
			$display("Bound assertions failed %0d times", uut.control.checks.failures);
		errorCount += uut.control.checks.failures;
		$display("Tests run %0d, failed %0d, checks %0d, errors %0d", testsRun, testsFailed,
			checkCount, errorCount);
		if (errorCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (cycleLimit) @(posedge clk);
		$display("Timeout after %0d cycles, the tests did not complete", cycleLimit);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
common/cr16Pkg.sv
alu/alu.sv
rtl/registerFile.sv
rtl/instructionControl.sv
rtl/cr16Execute.sv
verification/clockGen.sv
verification/cr16Execute_asserts.sv
verification/tbCr16Execute.sv

// ==== Bender.yml ====
package:
  name: cr16Execute

sources:
  - common/cr16Pkg.sv
  - alu/alu.sv
  - rtl/registerFile.sv
  - rtl/instructionControl.sv
  - rtl/cr16Execute.sv
  - target: simulation
    files:
      - verification/clockGen.sv
      - verification/cr16Execute_asserts.sv
      - verification/tbCr16Execute.sv
